/* Makefile */
# Verilator build and run of the user clock testbench

VERILATOR ?= verilator
TOP       ?= tb_uclk
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

PASS_MSG  := === PASS ===

SRCS := $(filter-out +%,$(shell cat $(FILELIST))) uclk_cfg.svh
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q -F -- "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* build.f */
+incdir+.
uclk_pkg.sv
uclk_cmd_decode.sv
uclk_rcfg_fsm.sv
pll_csr_bank.sv
uclk_freq_counter.sv
uclk_status.sv
uclk_top.sv
tb_uclk.sv

/* pll_csr_bank.sv */
`timescale 1ns/1ns
`default_nettype none

`include "uclk_cfg.svh"

module pll_csr_bank (
   input  wire                          clk,
   input  wire                          mgmt_reset,
   input  wire                          pll_reset,
   input  wire uclk_pkg::pll_mgmt_req_t mgmt_req,
   output logic                         waitrequest,
   output uclk_pkg::pll_byte_t          readdata,
   output logic                         locked
);

   import uclk_pkg::*;

   localparam int ws_w = $clog2(`PLL_WAIT_STATES + 1);
   localparam int lk_w = $clog2(`PLL_LOCK_DELAY + 1);

   pll_byte_t       regs [1024];   // PLL register file
   rcfg_addr_t      addr_q;        // Address of the pending access
   logic [ws_w-1:0] wait_cnt;
   logic [lk_w-1:0] lock_cnt;

   assign waitrequest = (wait_cnt != '0);

   //------------------------------------------------------------
   // Management port
   //------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (mgmt_reset) begin
         wait_cnt <= '0;
         for (int i = 0; i < 1024; i++) begin
            regs[i] <= '0;
         end
      end else if (!waitrequest && (mgmt_req.read || mgmt_req.write)) begin
         wait_cnt <= ws_w'(`PLL_WAIT_STATES);
         addr_q   <= mgmt_req.addr;
         if (mgmt_req.write) begin
            regs[mgmt_req.addr] <= mgmt_req.writedata;
         end
      end else if (waitrequest) begin
         wait_cnt <= wait_cnt - 1'b1;
         if (wait_cnt == ws_w'(1)) begin
            readdata <= regs[addr_q];   // Valid as waitrequest drops
         end
      end
   end

   //------------------------------------------------------------
   // Lock timer
   //------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (pll_reset) begin
         lock_cnt <= '0;
      end else if (!locked) begin
         lock_cnt <= lock_cnt + 1'b1;
      end
   end

   assign locked = (lock_cnt == lk_w'(`PLL_LOCK_DELAY));   // Saturates here

endmodule

`default_nettype wire

/* tb_uclk.sv */
`timescale 1ns/1ns
`default_nettype none

`include "uclk_cfg.svh"

module tb_uclk;

   import uclk_pkg::*;

   localparam int clk_period  = 10;
   localparam int uclk_period = 4;                   // 250 MHz
   localparam int xfer_limit  = 40;                  // Cycles allowed per transaction
   localparam int run_limit   = 40 * xfer_limit + 3 * `FREQ_WINDOW;
   localparam int freq_limit  = 2 * `FREQ_WINDOW + 100;
   localparam freq_t exp_uclk = freq_t'(`FREQ_WINDOW * clk_period / uclk_period);
   localparam freq_t exp_div2 = freq_t'(`FREQ_WINDOW * clk_period / (2 * uclk_period));

   logic      clk = 1'b0;
   logic      uclk = 1'b0;
   logic      uclk_div2 = 1'b0;
   logic      uclk_reset_n = 1'b0;
   cmd_word_t freq_cmd_0 = '0;
   cmd_word_t freq_cmd_1 = '0;
   sts_word_t freq_sts_0;
   sts_word_t freq_sts_1;

   integer     seed = 32'h992f_69ce;
   int         err_cnt = 0;
   int         timeout_cnt = 0;
   int         cycle_cnt = 0;

   //------------------------------------------------------------
   // Reference model state
   //------------------------------------------------------------
   pll_byte_t  model_mem [1024];   // Mirror of the PLL registers
   rcfg_addr_t remap_to [8] = '{10'h11f, 10'h120, 10'h121, 10'h122,
                                10'h123, 10'h124, 10'h125, 10'h126};
   rcfg_ctrl_t cmd_ctrl;           // Fields as driven with the address not remapped
   rcfg_ctrl_t model_rb;           // Expected readback
   rcfg_seq_t  seq_cnt;
   logic       lvl_pll;
   logic       lvl_mgmt;
   logic       lvl_fsm;
   logic       model_locked;
   rcfg_addr_t wr_addr [8];

   always #(clk_period / 2) clk = ~clk;
   always #(uclk_period / 2) uclk = ~uclk;

   always @(posedge uclk) begin
      uclk_div2 <= ~uclk_div2;   // Divide by two
   end

   uclk_top #(
      .AGILEX_REMAP (1)
   ) dut0 (
      .clk          (clk),
      .uclk_reset_n (uclk_reset_n),
      .uclk         (uclk),
      .uclk_div2    (uclk_div2),
      .freq_cmd_0   (freq_cmd_0),
      .freq_cmd_1   (freq_cmd_1),
      .freq_sts_0   (freq_sts_0),
      .freq_sts_1   (freq_sts_1)
   );

   // Run limit covering all transactions and three windows
   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= run_limit) begin
         $display("Run did not finish within %0d cycles", run_limit);
         $display("Errors: %0d  timeouts: %0d", err_cnt, timeout_cnt + 1);
         $display("=== FAIL ===");
         $finish;
      end
   end

   function automatic logic [31:0] rand32();
      return $random(seed);
   endfunction

   // Counter registers 0x11B..0x122 move up by four
   function automatic rcfg_addr_t remap_addr(input rcfg_addr_t a);
      rcfg_addr_t m;
      m = a;
      for (int i = 0; i < 8; i++) begin
         if (a == 10'h11b + 10'(i)) begin
            m = remap_to[i[2:0]];
         end
      end
      return m;
   endfunction

   function automatic cmd_word_t pack_cmd();
      cmd_word_t w;
      w        = '0;
      w[57]    = lvl_pll;
      w[56]    = lvl_mgmt;
      w[52]    = lvl_fsm;          // Machine enable, active high
      w[49:48] = cmd_ctrl.seq;
      w[44]    = cmd_ctrl.write;
      w[41:32] = cmd_ctrl.addr;
      w[31:0]  = cmd_ctrl.data;
      return w;
   endfunction

   function automatic sts_word_t expect_sts0();
      sts_word_t w;
      w        = '0;               // Error never expected
      w[60]    = model_locked;
      w[57]    = lvl_pll;
      w[56]    = lvl_mgmt;
      w[52]    = lvl_fsm;
      w[49:48] = model_rb.seq;
      w[44]    = model_rb.write;
      w[41:32] = model_rb.addr;
      w[31:0]  = model_rb.data;
      return w;
   endfunction

   //------------------------------------------------------------
   // Compare tasks
   //------------------------------------------------------------
   task automatic check_sts0(input sts_word_t got, input sts_word_t exp);
      if (got !== exp) begin
         $display("ERROR freq_sts_0: got %h expected %h at %0t", got, exp, $time);
         err_cnt++;
      end
   endtask

   task automatic check_freq(input freq_t got, input freq_t exp);
      int d;
      d = int'(got) - int'(exp);
      if ($isunknown(got) || d > 1 || d < -1) begin
         $display("ERROR freq_sts_1[16:0]: got %h expected %h +-1", got, exp);
         err_cnt++;
      end
   endtask

   // Version, reference, select echo and zero reserved bits
   task automatic check_const(input sts_word_t got, input logic sel);
      sts_word_t exp;
      sts_word_t fix;
      exp        = '0;
      exp[63:60] = `UCLK_VERSION;
      exp[50:33] = `UCLK_REF_FREQ;
      exp[32]    = sel;
      fix        = got;
      fix[16:0]  = '0;             // Count has its own check
      if (fix !== exp) begin
         $display("ERROR freq_sts_1: got %h expected %h outside [16:0]", got, exp);
         err_cnt++;
      end
   endtask

   //------------------------------------------------------------
   // Stimulus helpers
   //------------------------------------------------------------
   task automatic drive_cmd();
      @(posedge clk);
      freq_cmd_0 <= pack_cmd();
   endtask

   task automatic wait_bit(input logic [5:0] idx, input logic val, input int limit,
                           input string what, output int n);
      n = 0;
      @(negedge clk);
      while (freq_sts_0[idx] !== val && n < limit) begin
         @(negedge clk);
         n++;
      end
      if (freq_sts_0[idx] !== val) begin
         $display("Timed out after %0d cycles waiting for %s", limit, what);
         timeout_cnt++;
      end
   endtask

   // One management cycle started by a new seq
   task automatic do_xfer(input logic wr, input rcfg_addr_t addr, input pll_byte_t data);
      rcfg_addr_t  dev;
      pll_byte_t   exp_byte;
      logic [31:0] r;
      int          n;
      dev            = remap_addr(addr);
      r              = rand32();
      seq_cnt        = seq_cnt + 2'd1;
      cmd_ctrl.seq   = seq_cnt;
      cmd_ctrl.write = wr;
      cmd_ctrl.addr  = addr;
      cmd_ctrl.data  = {r[31:8], data};   // Upper bits never reach the port
      if (wr) begin
         model_mem[dev] = data;
         exp_byte       = 8'hff;
      end else begin
         exp_byte = model_mem[dev];
      end
      drive_cmd();
      n = 0;
      @(negedge clk);
      while (freq_sts_0[49:48] != seq_cnt && n < xfer_limit) begin
         @(negedge clk);
         n++;
      end
      if (freq_sts_0[49:48] != seq_cnt) begin
         $display("No status update for seq %0d at address %h", seq_cnt, addr);
         timeout_cnt++;
      end else begin
         model_rb.seq   = seq_cnt;
         model_rb.write = wr;
         model_rb.addr  = dev;            // Status shows the device address
         model_rb.data  = {24'h0, exp_byte};
         check_sts0(freq_sts_0, expect_sts0());
      end
   endtask

   task automatic pulse_mgmt();
      int n;
      lvl_mgmt = 1'b1;
      drive_cmd();
      wait_bit(6'd56, 1'b1, 8, "mgmt_reset echo", n);
      check_sts0(freq_sts_0, expect_sts0());
      for (int i = 0; i < 1024; i++) begin
         model_mem[i[9:0]] = '0;
      end
      lvl_mgmt = 1'b0;
      drive_cmd();
      wait_bit(6'd56, 1'b0, 8, "mgmt_reset release", n);
   endtask

   task automatic wait_lock(input int min_cycles);
      int n;
      wait_bit(6'd60, 1'b1, `PLL_LOCK_DELAY + 10, "PLL lock", n);
      if (n < min_cycles) begin
         $display("PLL locked after %0d cycles, sooner than %0d", n, min_cycles);
         err_cnt++;
      end
      model_locked = 1'b1;
      check_sts0(freq_sts_0, expect_sts0());
   endtask

   // Waits for the next count which always differs from the previous one
   task automatic measure_freq(input logic sel, input freq_t exp);
      logic [31:0] r_hi;
      logic [31:0] r_lo;
      freq_t       old;
      int          n;
      r_hi    = rand32();
      r_lo    = rand32();
      r_hi[0] = sel;                      // Bit 32 with the others ignored
      @(posedge clk);
      freq_cmd_1 <= {r_hi, r_lo};
      old = freq_sts_1[16:0];
      n   = 0;
      @(negedge clk);
      while (freq_sts_1[16:0] == old && n < freq_limit) begin
         @(negedge clk);
         n++;
      end
      if (freq_sts_1[16:0] == old) begin
         $display("Frequency count did not update within %0d cycles", freq_limit);
         timeout_cnt++;
      end else begin
         check_freq(freq_sts_1[16:0], exp);
         check_const(freq_sts_1, sel);
      end
   endtask

   //------------------------------------------------------------
   // Test sequence
   //------------------------------------------------------------
   initial begin
      int          n;
      logic [31:0] r;
      lvl_pll      = 1'b0;
      lvl_mgmt     = 1'b0;
      lvl_fsm      = 1'b0;
      model_locked = 1'b0;
      seq_cnt      = '0;
      cmd_ctrl     = '0;
      model_rb     = '0;
      repeat (8) @(posedge clk);
      uclk_reset_n <= 1'b1;

      // Reset values before lock
      repeat (4) @(negedge clk);
      check_sts0(freq_sts_0, expect_sts0());
      check_const(freq_sts_1, 1'b0);
      check_freq(freq_sts_1[16:0], '0);
      wait_lock(`PLL_LOCK_DELAY - 4);      // Reset checks used four cycles of the delay

      lvl_fsm = 1'b1;
      pulse_mgmt();                        // Clear the register file

      // Random writes then reads back in reverse
      for (int i = 0; i < 8; i++) begin
         r = rand32();
         wr_addr[i[2:0]] = r[31] ? 10'h118 + {5'd0, r[4:0]} : r[9:0];
         do_xfer(1'b1, wr_addr[i[2:0]], r[23:16]);
      end
      for (int i = 7; i >= 0; i--) begin
         do_xfer(1'b0, wr_addr[i[2:0]], 8'h00);
      end

      // Remapped counters and their direct aliases
      for (int i = 0; i < 8; i++) begin
         r = rand32();
         do_xfer(1'b1, 10'h11b + 10'(i), r[7:0]);
      end
      for (int i = 0; i < 4; i++) begin
         do_xfer(1'b0, 10'h123 + 10'(i), 8'h00);
      end

      // Management reset clears and PLL reset drops lock
      pulse_mgmt();
      do_xfer(1'b0, 10'h11b, 8'h00);
      do_xfer(1'b0, 10'h123, 8'h00);
      lvl_pll      = 1'b1;
      model_locked = 1'b0;
      drive_cmd();
      wait_bit(6'd60, 1'b0, 8, "loss of lock", n);
      check_sts0(freq_sts_0, expect_sts0());
      lvl_pll = 1'b0;
      drive_cmd();
      wait_lock(`PLL_LOCK_DELAY);

      // Machine held in reset ignores seq
      lvl_fsm = 1'b0;
      drive_cmd();
      wait_bit(6'd52, 1'b0, 8, "machine reset echo", n);
      for (int i = 0; i < 2; i++) begin
         r              = rand32();
         seq_cnt        = seq_cnt + 2'd1;
         cmd_ctrl.seq   = seq_cnt;
         cmd_ctrl.write = r[0];
         cmd_ctrl.addr  = r[17:8];
         drive_cmd();
         repeat (xfer_limit) @(negedge clk);
         check_sts0(freq_sts_0, expect_sts0());
      end
      lvl_fsm = 1'b1;
      drive_cmd();
      wait_bit(6'd52, 1'b1, 8, "machine release", n);
      r = rand32();
      do_xfer(1'b1, r[9:0], r[31:24]);     // Served again after release

      // Frequency of div2 first as selected since reset
      measure_freq(1'b0, exp_div2);
      measure_freq(1'b1, exp_uclk);

      $display("Errors: %0d  timeouts: %0d", err_cnt, timeout_cnt);
      if (err_cnt == 0 && timeout_cnt == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* uclk_cfg.svh */
`ifndef UCLK_CFG_SVH
`define UCLK_CFG_SVH

// Feature version reported in status word 1
`define UCLK_VERSION     4'd4
// Reference clock in 10 kHz units
`define UCLK_REF_FREQ    18'd10000

// Management port model
`define PLL_WAIT_STATES  3
`define PLL_LOCK_DELAY   20

// Waitrequest high cycles tolerated by the machine
`define RCFG_TIMEOUT     64

// Measurement window in clk cycles, 100 us at 100 MHz
`define FREQ_WINDOW      10000

`endif

/* uclk_cmd_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module uclk_cmd_decode #(
   parameter int AGILEX_REMAP = 0
) (
   input  wire                     clk,
   input  wire                     uclk_reset_n,
   input  wire uclk_pkg::cmd_word_t cmd,
   output uclk_pkg::rcfg_ctrl_t    rcfg_ctrl,
   output logic                    pll_reset,
   output logic                    mgmt_reset,
   output logic                    fsm_reset_n
);

   import uclk_pkg::*;

   cmd_word_t  cmd_q1;     // First stage, raw command
   rcfg_addr_t addr_raw;
   rcfg_addr_t addr_map;

   assign addr_raw = cmd_q1[41:32];

   //------------------------------------------------------------
   // Output counter remap for the newer PLL family
   //------------------------------------------------------------
   // C0 is unused there, so C0 and C1 registers move up to C1 and C2
   always_comb begin
      addr_map = addr_raw;
      if (AGILEX_REMAP == 1) begin
         if (addr_raw >= 10'h11b && addr_raw <= 10'h122) begin
            addr_map = addr_raw + 10'd4;   // Four registers per counter
         end
      end
   end

   //------------------------------------------------------------
   // Two register stages
   //------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (!uclk_reset_n) begin
         cmd_q1      <= '0;
         rcfg_ctrl   <= '0;
         pll_reset   <= 1'b1;   // PLL held in reset with the system
         mgmt_reset  <= 1'b0;
         fsm_reset_n <= 1'b0;   // Machine stays off until software enables it
      end else begin
         cmd_q1          <= cmd;
         pll_reset       <= cmd_q1[57];      // PLL powerdown
         mgmt_reset      <= cmd_q1[56];      // Management port reset
         fsm_reset_n     <= cmd_q1[52];      // Machine reset, active low
         rcfg_ctrl.seq   <= cmd_q1[49:48];
         rcfg_ctrl.write <= cmd_q1[44];
         rcfg_ctrl.addr  <= addr_map;        // Device address after remap
         rcfg_ctrl.data  <= cmd_q1[31:0];
      end
   end

endmodule

`default_nettype wire

/* uclk_freq_counter.sv */
`timescale 1ns/1ns
`default_nettype none

`include "uclk_cfg.svh"

module uclk_freq_counter (
   input  wire             clk,
   input  wire             uclk_reset_n,
   input  wire             uclk,
   input  wire             uclk_div2,
   input  wire             sel_uclk,
   output logic            freq_valid,
   output uclk_pkg::freq_t freq_value
);

   import uclk_pkg::*;

   localparam int win_w = $clog2(`FREQ_WINDOW);
   localparam logic [win_w-1:0] win_last = win_w'(`FREQ_WINDOW - 1);

   function automatic freq_t gray2bin(input freq_t g);
      freq_t b;
      b[$bits(freq_t)-1] = g[$bits(freq_t)-1];
      for (int i = $bits(freq_t) - 2; i >= 0; i--) begin
         b[i] = b[i+1] ^ g[i];
      end
      return b;
   endfunction

   wire [1:0]        src_clk;   // Index 0 uclk, 1 uclk_div2
   freq_t            sample [2];
   freq_t            prev [2];  // Sample at the previous boundary
   logic [win_w-1:0] win_cnt;
   logic             first_done;

   assign src_clk = {uclk_div2, uclk};

   //------------------------------------------------------------
   // Edge counters and clock crossing
   //------------------------------------------------------------
   for (genvar g = 0; g < 2; g++) begin : g_src
      freq_t bin_cnt;    // Wraps, only differences are used
      freq_t gray_cnt;
      freq_t gray_s1;
      freq_t gray_s2;
      freq_t gray_s3;

      always_ff @(posedge src_clk[g]) begin
         bin_cnt  <= bin_cnt + 1'b1;
         gray_cnt <= bin_cnt ^ (bin_cnt >> 1);   // One bit changes per edge
      end

      always_ff @(posedge clk) begin
         gray_s1 <= gray_cnt;
         gray_s2 <= gray_s1;
         gray_s3 <= gray_s2;
      end

      assign sample[g] = gray2bin(gray_s3);
   end

   //------------------------------------------------------------
   // Window timing
   //------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (!uclk_reset_n) begin
         win_cnt    <= '0;
         first_done <= 1'b0;
         freq_valid <= 1'b0;
      end else begin
         freq_valid <= 1'b0;
         if (win_cnt == win_last) begin
            win_cnt    <= '0;
            first_done <= 1'b1;
            freq_valid <= first_done;   // First window has no start sample
         end else begin
            win_cnt <= win_cnt + 1'b1;
         end
      end
   end

   // Both sources sampled so a select change gives a clean result
   always_ff @(posedge clk) begin
      if (win_cnt == win_last) begin
         prev[0]    <= sample[0];
         prev[1]    <= sample[1];
         freq_value <= sel_uclk ? sample[0] - prev[0] : sample[1] - prev[1];
      end
   end

endmodule

`default_nettype wire

/* uclk_pkg.sv */
`default_nettype none

package uclk_pkg;

   // Software visible words
   typedef logic [63:0] cmd_word_t;
   typedef logic [63:0] sts_word_t;

   typedef logic [9:0]  rcfg_addr_t;   // PLL management address
   typedef logic [31:0] rcfg_data_t;   // Command data field
   typedef logic [7:0]  pll_byte_t;    // One PLL register
   typedef logic [1:0]  rcfg_seq_t;    // Sequence tag
   typedef logic [16:0] freq_t;        // Count in 10 kHz units

   //------------------------------------------------------------
   // Decoded reconfiguration command, 45 bits
   //------------------------------------------------------------
   typedef struct packed {
      rcfg_seq_t  seq;
      logic       write;   // 1 write, 0 read
      rcfg_addr_t addr;
      rcfg_data_t data;
   } rcfg_ctrl_t;

   // Management bus request, 20 bits
   typedef struct packed {
      logic       read;
      logic       write;
      rcfg_addr_t addr;
      pll_byte_t  writedata;
   } pll_mgmt_req_t;

   // Reconfiguration machine
   typedef enum logic [2:0] {
      st_idle,
      st_request,
      st_wait_read,
      st_latch,
      st_error
   } rcfg_state_t;

endpackage

`default_nettype wire

/* uclk_rcfg_fsm.sv */
`timescale 1ns/1ns
`default_nettype none

`include "uclk_cfg.svh"

module uclk_rcfg_fsm (
   input  wire                       clk,
   input  wire                       fsm_reset_n,
   input  wire uclk_pkg::rcfg_ctrl_t rcfg_ctrl,
   input  wire                       waitrequest,
   output uclk_pkg::pll_mgmt_req_t   mgmt_req,
   output logic                      read_latch,
   output logic                      error
);

   import uclk_pkg::*;

   localparam int tmo_w = $clog2(`RCFG_TIMEOUT + 1);
   localparam logic [tmo_w-1:0] tmo_max = tmo_w'(`RCFG_TIMEOUT);

   rcfg_state_t      state;
   rcfg_seq_t        last_seq;   // Sequence of the last cycle served
   logic [tmo_w-1:0] tmo_cnt;    // Waitrequest high cycles

   //------------------------------------------------------------
   // State register
   //------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (!fsm_reset_n) begin
         state    <= st_idle;
         last_seq <= rcfg_ctrl.seq;   // Follow seq so release starts nothing
         tmo_cnt  <= '0;
      end else begin
         case (state)
            st_idle: begin
               // New sequence starts exactly one cycle
               if (rcfg_ctrl.seq != last_seq) begin
                  last_seq <= rcfg_ctrl.seq;
                  state    <= st_request;
               end
            end
            st_request: begin
               tmo_cnt <= '0;
               state   <= st_wait_read;
            end
            st_wait_read: begin
               if (!waitrequest) begin
                  state <= st_latch;            // Read data valid now
               end else if (tmo_cnt == tmo_max) begin
                  state <= st_error;            // Port stuck
               end else begin
                  tmo_cnt <= tmo_cnt + 1'b1;
               end
            end
            st_latch: begin
               state <= st_idle;
            end
            st_error: begin
               state <= st_error;   // Left only by machine reset
            end
            default: begin
               state <= st_idle;
            end
         endcase
      end
   end

   //------------------------------------------------------------
   // Outputs
   //------------------------------------------------------------
   // Strobe lasts the single request cycle
   always_comb begin
      mgmt_req.read      = (state == st_request) && !rcfg_ctrl.write;
      mgmt_req.write     = (state == st_request) && rcfg_ctrl.write;
      mgmt_req.addr      = rcfg_ctrl.addr;
      mgmt_req.writedata = rcfg_ctrl.data[7:0];   // Port is byte wide
   end

   assign read_latch = (state == st_latch);
   assign error      = (state == st_error);

endmodule

`default_nettype wire

/* uclk_status.sv */
`timescale 1ns/1ns
`default_nettype none

`include "uclk_cfg.svh"

module uclk_status (
   input  wire                       clk,
   input  wire                       uclk_reset_n,
   input  wire uclk_pkg::rcfg_ctrl_t rcfg_ctrl,
   input  wire uclk_pkg::pll_byte_t  readdata,
   input  wire                       read_latch,
   input  wire                       error,
   input  wire                       locked,
   input  wire                       pll_reset,
   input  wire                       mgmt_reset,
   input  wire                       fsm_reset_n,
   input  wire                       sel_uclk,
   input  wire                       freq_valid,
   input  wire uclk_pkg::freq_t      freq_value,
   output uclk_pkg::sts_word_t       sts_0,
   output uclk_pkg::sts_word_t       sts_1
);

   import uclk_pkg::*;

   pll_byte_t  readdata_t1;   // Port data one cycle late
   rcfg_ctrl_t rb_latched;    // Readback of the last cycle
   logic [1:0] locked_sync;
   logic       error_q;
   logic       sel_q;
   freq_t      freq_q;

   always_ff @(posedge clk) begin
      readdata_t1 <= readdata;
   end

   always_ff @(posedge clk) begin
      if (!uclk_reset_n) begin
         rb_latched  <= '0;
         locked_sync <= '0;
         error_q     <= 1'b0;
         sel_q       <= 1'b0;
         freq_q      <= '0;
      end else begin
         locked_sync <= {locked_sync[0], locked};
         error_q     <= error;
         sel_q       <= sel_uclk;
         if (read_latch) begin
            rb_latched.seq   <= rcfg_ctrl.seq;
            rb_latched.write <= rcfg_ctrl.write;
            rb_latched.addr  <= rcfg_ctrl.addr;
            // Writes read back as all ones
            rb_latched.data  <= {24'h0, readdata_t1 | {8{rcfg_ctrl.write}}};
         end
         if (freq_valid) begin
            freq_q <= freq_value;
         end
      end
   end

   //------------------------------------------------------------
   // Status words
   //------------------------------------------------------------
   assign sts_0 = {error_q, 2'b0, locked_sync[1], 2'b0,   // 63..58
                   pll_reset, mgmt_reset, 3'b0,           // 57..53
                   fsm_reset_n, 2'b0, rb_latched.seq,     // 52..48
                   3'b0, rb_latched.write, 2'b0,          // 47..42
                   rb_latched.addr, rb_latched.data};     // 41..0

   assign sts_1 = {`UCLK_VERSION, 9'b0, `UCLK_REF_FREQ,   // 63..33
                   sel_q, 15'b0, freq_q};                  // 32..0

endmodule

`default_nettype wire

/* uclk_top.sv */
`timescale 1ns/1ns
`default_nettype none

module uclk_top #(
   parameter int AGILEX_REMAP = 0
) (
   input  wire                      clk,
   input  wire                      uclk_reset_n,
   input  wire                      uclk,
   input  wire                      uclk_div2,
   input  wire uclk_pkg::cmd_word_t freq_cmd_0,   // Reconfiguration command
   input  wire uclk_pkg::cmd_word_t freq_cmd_1,   // Counter select
   output wire uclk_pkg::sts_word_t freq_sts_0,
   output wire uclk_pkg::sts_word_t freq_sts_1
);

   import uclk_pkg::*;

   wire rcfg_ctrl_t    rcfg_ctrl;
   wire                pll_reset;
   wire                mgmt_reset;
   wire                fsm_reset_n;
   wire pll_mgmt_req_t mgmt_req;
   wire                waitrequest;
   wire pll_byte_t     readdata;
   wire                read_latch;
   wire                error;
   wire                locked;
   wire                freq_valid;
   wire freq_t         freq_value;

   //------------------------------------------------------------
   // Command path
   //------------------------------------------------------------
   uclk_cmd_decode #(
      .AGILEX_REMAP (AGILEX_REMAP)
   ) cmd_decode0 (
      .clk          (clk),
      .uclk_reset_n (uclk_reset_n),
      .cmd          (freq_cmd_0),
      .rcfg_ctrl    (rcfg_ctrl),
      .pll_reset    (pll_reset),
      .mgmt_reset   (mgmt_reset),
      .fsm_reset_n  (fsm_reset_n)
   );

   uclk_rcfg_fsm rcfg_fsm0 (
      .clk         (clk),
      .fsm_reset_n (fsm_reset_n),   // Own reset only
      .rcfg_ctrl   (rcfg_ctrl),
      .waitrequest (waitrequest),
      .mgmt_req    (mgmt_req),
      .read_latch  (read_latch),
      .error       (error)
   );

   pll_csr_bank csr_bank0 (
      .clk         (clk),
      .mgmt_reset  (mgmt_reset),
      .pll_reset   (pll_reset),
      .mgmt_req    (mgmt_req),
      .waitrequest (waitrequest),
      .readdata    (readdata),
      .locked      (locked)
   );

   //------------------------------------------------------------
   // Measurement branch and status
   //------------------------------------------------------------
   uclk_freq_counter freq_counter0 (
      .clk          (clk),
      .uclk_reset_n (uclk_reset_n),
      .uclk         (uclk),
      .uclk_div2    (uclk_div2),
      .sel_uclk     (freq_cmd_1[32]),   // 1 measures uclk
      .freq_valid   (freq_valid),
      .freq_value   (freq_value)
   );

   uclk_status status0 (
      .clk          (clk),
      .uclk_reset_n (uclk_reset_n),
      .rcfg_ctrl    (rcfg_ctrl),
      .readdata     (readdata),
      .read_latch   (read_latch),
      .error        (error),
      .locked       (locked),
      .pll_reset    (pll_reset),
      .mgmt_reset   (mgmt_reset),
      .fsm_reset_n  (fsm_reset_n),
      .sel_uclk     (freq_cmd_1[32]),
      .freq_valid   (freq_valid),
      .freq_value   (freq_value),
      .sts_0        (freq_sts_0),
      .sts_1        (freq_sts_1)
   );

endmodule

`default_nettype wire
